// ==== src/rv32i_pkg.sv ====
package rv32i_pkg;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // one instruction word, two ways of reading it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_t;

  typedef enum logic [2:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LUI,
    CLS_LOAD,
    CLS_STORE,
    CLS_NOP
  } instr_class_e;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK
  } ctrl_state_e;

  typedef enum logic {B_REG, B_IMM} b_sel_e;   // alu operand b source
  typedef enum logic {WB_ALU, WB_MEM} wb_sel_e; // register write-back source

endpackage

// ==== src/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if import rv32i_pkg::*; ();

  logic [4:0]   rs1;
  logic [4:0]   rs2;
  logic [4:0]   rd;
  logic [31:0]  imm;     // already sign extended
  alu_op_t      alu_op;
  instr_class_e iclass;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, iclass
  );

  modport control (
    input iclass, alu_op
  );

  // register indices and immediate for the datapath
  modport datapath (
    input rs1, rs2, rd, imm
  );

endinterface

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import rv32i_pkg::*; (
  input  instr_t           instr,
  decode_if.decoder        dec
);

  logic is_alt; // funct7 bit 5 picks sub / sra

  assign is_alt = instr.r.funct7[5];

  always_comb begin
    dec.rs1    = instr.r.rs1;
    dec.rs2    = instr.r.rs2;
    dec.rd     = instr.r.rd;
    dec.imm    = {{20{instr.i.imm12[11]}}, instr.i.imm12}; // I format
    dec.alu_op = ALU_ADD;
    dec.iclass = CLS_NOP;

    case (opcode_e'(instr.r.opcode))
      OP, OP_IMM: begin
        dec.iclass = (instr.r.opcode == OP) ? CLS_ALU_REG : CLS_ALU_IMM;
        case (instr.r.funct3)
          3'b000: begin
            // no subi, so only register form looks at funct7
            if (instr.r.opcode == OP && is_alt)
              dec.alu_op = ALU_SUB;
            else
              dec.alu_op = ALU_ADD;
          end
          3'b001: dec.alu_op = ALU_SLL;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b101: dec.alu_op = is_alt ? ALU_SRA : ALU_SRL;
          3'b110: dec.alu_op = ALU_OR;
          default: dec.alu_op = ALU_AND;
        endcase
      end
      LUI: begin
        dec.iclass = CLS_LUI;
        dec.rs1    = 5'd0; // operand a comes from x0
        dec.imm    = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'd0};
      end
      LOAD: dec.iclass = CLS_LOAD;
      STORE: begin
        dec.iclass = CLS_STORE;
        // S format splits the offset around rd
        dec.imm    = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
      end
      default: dec.iclass = CLS_NOP;
    endcase
  end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import rv32i_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  output logic [31:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0]; // only the low five bits shift
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_SLT:  result = {31'd0, lt_signed};
      ALU_SLTU: result = {31'd0, lt_unsigned};
      default:  result = 32'd0;
    endcase
  end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic        clk,
  input  logic        wr_ena,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  input  logic [4:0]  rd_addr0,
  input  logic [4:0]  rd_addr1,
  output logic [31:0] rd_data0,
  output logic [31:0] rd_data1
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (wr_ena && wr_addr != 5'd0)
      regs[wr_addr] <= wr_data;
  end

  assign rd_data0 = (rd_addr0 == 5'd0) ? 32'd0 : regs[rd_addr0];
  assign rd_data1 = (rd_addr1 == 5'd0) ? 32'd0 : regs[rd_addr1];

  // a write aimed at x0 is dropped and leaves every register as it was
  x0_write_dropped: assert property (
    @(posedge clk) ($past(wr_ena && wr_addr == 5'd0) && $stable(rd_addr0) && $stable(rd_addr1))
      |-> ($stable(rd_data0) && $stable(rd_data1))
  );

endmodule

// ==== src/multicycle_control.sv ====
`timescale 1ns/1ps

module multicycle_control import rv32i_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        ena,
  decode_if.control   dec,
  output ctrl_state_e state,
  output logic        pc_ena,
  output logic        instr_ena,
  output logic        operand_ena,
  output logic        result_ena,
  output logic        mdata_ena,
  output logic        reg_write,
  output b_sel_e      b_sel,
  output wb_sel_e     wb_sel,
  output alu_op_t     alu_op,
  output logic        mem_wr_ena,
  output logic        retire
);

  ctrl_state_e next_state;
  logic        is_load;
  logic        is_store;
  logic        is_nop;

  assign is_load  = dec.iclass == CLS_LOAD;
  assign is_store = dec.iclass == CLS_STORE;
  assign is_nop   = dec.iclass == CLS_NOP;

  always_ff @(posedge clk) begin
    if (rst)
      state <= S_FETCH;
    else if (ena) // stalled cycles hold the state
      state <= next_state;
  end

  always_comb begin
    next_state = S_FETCH;
    case (state)
      S_FETCH:  next_state = S_DECODE;
      S_DECODE: next_state = is_nop ? S_FETCH : S_EXECUTE;
      S_EXECUTE: begin
        if (is_load || is_store)
          next_state = S_MEMORY;
        else
          next_state = S_WRITEBACK;
      end
      S_MEMORY:    next_state = is_load ? S_WRITEBACK : S_FETCH;
      S_WRITEBACK: next_state = S_FETCH;
      default:     next_state = S_FETCH;
    endcase
  end

  // every enable and strobe is qualified by ena
  always_comb begin
    pc_ena      = 1'b0;
    instr_ena   = 1'b0;
    operand_ena = 1'b0;
    result_ena  = 1'b0;
    mdata_ena   = 1'b0;
    reg_write   = 1'b0;
    mem_wr_ena  = 1'b0;
    retire      = 1'b0;
    alu_op      = ALU_ADD;

    case (state)
      S_FETCH: begin
        pc_ena    = ena;
        instr_ena = ena;
      end
      S_DECODE: begin
        operand_ena = ena;
        retire      = ena && is_nop; // unknown opcode ends here
      end
      S_EXECUTE: begin
        result_ena = ena;
        alu_op     = dec.alu_op;
      end
      S_MEMORY: begin
        mdata_ena  = ena && is_load;
        mem_wr_ena = ena && is_store;
        retire     = ena && is_store;
      end
      S_WRITEBACK: begin
        reg_write = ena;
        retire    = ena;
      end
      default: ;
    endcase
  end

  // register form is the only one that reads rs2 into the alu
  assign b_sel  = (dec.iclass == CLS_ALU_REG) ? B_REG : B_IMM;
  assign wb_sel = is_load ? WB_MEM : WB_ALU;

  store_write_in_memory_state: assert property (
    @(posedge clk) disable iff (rst)
      mem_wr_ena |-> state == S_MEMORY && dec.iclass == CLS_STORE
  );

  no_reg_write_on_store: assert property (
    @(posedge clk) disable iff (rst)
      reg_write |-> dec.iclass != CLS_STORE
  );

  // every instruction takes at least two cycles
  retire_single_cycle: assert property (
    @(posedge clk) disable iff (rst)
      retire |=> !retire
  );

endmodule

// ==== src/rv32i_multicycle_core.sv ====
`timescale 1ns/1ps

module rv32i_multicycle_core import rv32i_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'd0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        ena,
  input  logic [31:0] mem_rd_data,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_ena,
  output logic [31:0] pc,
  output logic        retire
);

  ctrl_state_e state;
  logic        pc_ena, instr_ena, operand_ena, result_ena, mdata_ena, reg_write;
  b_sel_e      b_sel;
  wb_sel_e     wb_sel;
  alu_op_t     alu_op;
  instr_t      instr_q;
  logic [31:0] opa_q, opb_q, result_q, mdata_q;
  logic [31:0] rf_data0, rf_data1, alu_b, alu_out, wb_data;

  decode_if dec_bus ();

  instr_decoder u_decoder (.instr(instr_q), .dec(dec_bus));

  always_ff @(posedge clk) begin
    if (rst)
      pc <= reset_pc;
    else if (pc_ena)
      pc <= pc + 32'd4; // pc always points at the next fetch
  end

  always_ff @(posedge clk) begin
    if (instr_ena)
      instr_q <= mem_rd_data;
    if (operand_ena) begin
      opa_q <= rf_data0; // lui reads x0 here
      opb_q <= rf_data1;
    end
    if (result_ena)
      result_q <= alu_out;
    if (mdata_ena)
      mdata_q <= mem_rd_data;
  end

  register_file u_regs (
    .clk(clk), .wr_ena(reg_write), .wr_addr(dec_bus.rd), .wr_data(wb_data),
    .rd_addr0(dec_bus.rs1), .rd_addr1(dec_bus.rs2),
    .rd_data0(rf_data0), .rd_data1(rf_data1)
  );

  assign alu_b = (b_sel == B_IMM) ? dec_bus.imm : opb_q;

  alu u_alu (.a(opa_q), .b(alu_b), .op(alu_op), .result(alu_out));

  assign wb_data     = (wb_sel == WB_MEM) ? mdata_q : result_q;
  assign mem_addr    = (state == S_FETCH) ? pc : result_q; // shared port
  assign mem_wr_data = opb_q;

  multicycle_control u_ctrl (
    .clk(clk), .rst(rst), .ena(ena), .dec(dec_bus), .state(state),
    .pc_ena(pc_ena), .instr_ena(instr_ena), .operand_ena(operand_ena),
    .result_ena(result_ena), .mdata_ena(mdata_ena), .reg_write(reg_write),
    .b_sel(b_sel), .wb_sel(wb_sel), .alu_op(alu_op),
    .mem_wr_ena(mem_wr_ena), .retire(retire)
  );

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import rv32i_pkg::*; ();

  logic clk, rst, ena, mem_wr_ena, retire;
  logic [31:0] mem_rd_data, mem_addr, mem_wr_data, pc;
  logic [31:0] mem [0:255];  // 1 KiB of word addressed memory
  logic [31:0] regs [0:31];  // reference register state
  logic [31:0] rng = 32'h97d5_0479;
  logic [31:0] expected_pc, t_start, limit;
  logic [31:0] snap [0:9];
  int          retired = 0, p;
  logic        running = 0;
  string       test_name = "";

  rv32i_multicycle_core #(.reset_pc(32'd0)) dut0 (
    .clk(clk), .rst(rst), .ena(ena), .mem_rd_data(mem_rd_data), .mem_addr(mem_addr),
    .mem_wr_data(mem_wr_data), .mem_wr_ena(mem_wr_ena), .pc(pc), .retire(retire)
  );

  assign mem_rd_data = mem[mem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h got %h", name, exp, act));
  endtask

  task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %s got %s", name, exp.name(), act.name()));
  endtask

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
  endfunction

  task automatic put(input logic [31:0] w);
    mem[p] = w;
    p = p + 1;
  endtask

  task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
    // addi sign extends, so the upper part is corrected by bit 11
    put({v[31:12] + {19'd0, v[11]}, rd, LUI});
    put(enc_i(v[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  // steps the model by the ISA rules for the instruction at expected_pc
  task automatic ref_step();
    logic [31:0] w, a, b, res, imm_i, imm_s;
    logic        alt;
    alu_op_t     eop;
    w = mem[expected_pc[9:2]];
    a = regs[w[19:15]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    check_word({test_name, " pc"}, expected_pc + 32'd4, pc);
    if (w[6:0] == OP || w[6:0] == OP_IMM) begin
      b = (w[6:0] == OP) ? regs[w[24:20]] : imm_i;
      alt = w[30] && (w[6:0] == OP || w[14:12] == 3'b101);
      case (w[14:12])
        3'b000: begin
          res = alt ? a - b : a + b;
          eop = alt ? ALU_SUB : ALU_ADD;
        end
        3'b001: begin
          res = a << b[4:0];
          eop = ALU_SLL;
        end
        3'b010: begin
          res = {31'd0, $signed(a) < $signed(b)};
          eop = ALU_SLT;
        end
        3'b011: begin
          res = {31'd0, a < b};
          eop = ALU_SLTU;
        end
        3'b100: begin
          res = a ^ b;
          eop = ALU_XOR;
        end
        3'b101: begin
          if (alt)
            res = $signed(a) >>> b[4:0]; // sign bit fills from the left
          else
            res = a >> b[4:0];
          eop = alt ? ALU_SRA : ALU_SRL;
        end
        3'b110: begin
          res = a | b;
          eop = ALU_OR;
        end
        default: begin
          res = a & b;
          eop = ALU_AND;
        end
      endcase
      check_alu_op({test_name, " alu_op"}, eop, dut0.dec_bus.alu_op);
      regs[w[11:7]] = res;
    end else if (w[6:0] == LUI) begin
      regs[w[11:7]] = {w[31:12], 12'd0};
    end else if (w[6:0] == LOAD) begin
      res = a + imm_i;
      regs[w[11:7]] = mem[res[9:2]];
    end else if (w[6:0] == STORE) begin
      check_word({test_name, " store strobe"}, 32'd1, {31'd0, mem_wr_ena});
      check_word({test_name, " store address"}, a + imm_s, mem_addr);
      check_word({test_name, " store data"}, regs[w[24:20]], mem_wr_data);
    end
    regs[0] = 32'd0;
    expected_pc = expected_pc + 32'd4;
  endtask

  // reference model, memory writes and strobe checks
  always @(posedge clk) begin
    if (rst) begin
      expected_pc = 32'd0;
    end else begin
      if (!ena && (retire || mem_wr_ena))
        fail_run("strobe raised in a stalled cycle");
      if (retire) begin
        ref_step();
        retired = retired + 1;
      end
      if (mem_wr_ena)
        mem[mem_addr[9:2]] = mem_wr_data;
    end
  end

  // allows 6 cycles per instruction times 2
  always @(posedge clk) begin
    if (running && ($time - t_start > limit)) begin
      $display("core stopped retiring before program end");
      $display("Test failed");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic run_program(input int n, input logic stall);
    int base;
    @(negedge clk);
    rst = 1'b1;
    ena = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    base = retired;
    limit = n * 6 * 2 * 8;
    t_start = $time;
    running = 1'b1;
    // the core is back in fetch just past the last instruction once all of them are done
    while (!(pc == 32'(4 * n) && dut0.state == S_FETCH)) begin
      ena = stall ? (next_rand() & 32'd3) != 32'd0 : 1'b1;
      @(negedge clk);
    end
    ena = 1'b0;
    running = 1'b0;
    repeat (3) @(negedge clk);
    check_word({test_name, " retire count"}, n, retired - base);
  endtask

  task automatic build_alu_program();
    p = 0;
    load_imm(5'd1, next_rand());
    load_imm(5'd2, next_rand());
    for (int k = 0; k < 10; k++) begin
      put(enc_r(k >= 8 ? 7'h20 : 7'h00, 5'd2, 5'd1, k == 9 ? 3'b101 : 3'(k % 8), 5'd3));
      put(enc_s(12'h200 + 12'(4 * k), 5'd3, 5'd0));
    end
  endtask

  task automatic test_alu_reg();
    test_name = "alu_reg";
    build_alu_program();
    run_program(24, 1'b0);
    for (int k = 0; k < 10; k++)
      snap[k] = mem[128 + k];
  endtask

  task automatic test_alu_imm();
    logic [14:0] ops [0:8];  // {funct3, imm12}
    ops = '{{3'd2, 12'hffc}, {3'd3, 12'hfff}, {3'd3, 12'h001}, {3'd1, 12'h01f},
            {3'd5, 12'h004}, {3'd5, 12'h404}, {3'd4, 12'hfff}, {3'd7, 12'h0f0},
            {3'd0, 12'h800}};
    test_name = "alu_imm";
    p = 0;
    put(enc_i(12'hffb, 5'd0, 3'b000, 5'd4, OP_IMM)); // x4 = -5
    for (int k = 0; k < 9; k++) begin
      put(enc_i(ops[k][11:0], 5'd4, ops[k][14:12], 5'd5, OP_IMM));
      put(enc_s(12'h280 + 12'(4 * k), 5'd5, 5'd0));
    end
    run_program(19, 1'b0);
  endtask

  task automatic test_load_store();
    logic [31:0] v0, v1;
    test_name = "load_store";
    v0 = next_rand();
    v1 = next_rand();
    p = 0;
    load_imm(5'd11, v0);
    load_imm(5'd12, v1);
    put(enc_s(12'h300, 5'd11, 5'd0));
    put(enc_s(12'h304, 5'd12, 5'd0));
    put(enc_i(12'h300, 5'd0, 3'b010, 5'd13, LOAD));
    put(enc_i(12'h304, 5'd0, 3'b010, 5'd14, LOAD));
    put(enc_s(12'h308, 5'd13, 5'd0));
    put(enc_s(12'h30c, 5'd14, 5'd0));
    put(enc_i(12'h005, 5'd11, 3'b000, 5'd0, OP_IMM)); // write to x0 is dropped
    put(enc_s(12'h310, 5'd0, 5'd0));
    run_program(12, 1'b0);
    check_word("load_store copy0", v0, mem[194]);
    check_word("load_store copy1", v1, mem[195]);
    check_word("load_store x0", 32'd0, mem[196]);
  endtask

  task automatic test_retire_nop();
    test_name = "retire_nop";
    p = 0;
    put(enc_i(12'h007, 5'd0, 3'b000, 5'd15, OP_IMM));
    put({20'h12345, 5'd15, 7'b0001011}); // custom opcode that must not touch x15
    put(enc_s(12'h320, 5'd15, 5'd0));
    run_program(3, 1'b0);
    check_word("retire_nop x15", 32'd7, mem[200]);
  endtask

  task automatic test_stall();
    test_name = "stall";
    for (int k = 0; k < 10; k++)
      mem[128 + k] = 32'd0;
    rng = 32'h97d5_0479; // same operands as the unstalled run
    build_alu_program();
    run_program(24, 1'b1);
    for (int k = 0; k < 10; k++)
      check_word("stall data", snap[k], mem[128 + k]);
  endtask

  initial begin
    rst = 1'b1;
    ena = 1'b0;
    for (int k = 0; k < 256; k++)
      mem[k] = 32'h5a5a_0000 ^ (k * 32'h9e37_79b9);
    for (int k = 0; k < 32; k++)
      regs[k] = 32'd0;
    test_alu_reg();
    test_alu_imm();
    test_load_store();
    test_retire_nop();
    test_stall();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== rv32i_mc.f ====
src/rv32i_pkg.sv
src/decode_if.sv
src/instr_decoder.sv
src/alu.sv
src/register_file.sv
src/multicycle_control.sv
src/rv32i_multicycle_core.sv
tb/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run; a failing check ends in $fatal and a nonzero exit status
verilator --binary --timing --assert -f rv32i_mc.f --top-module tb_core -o tb_core_sim \
  && ./obj_dir/tb_core_sim \
  || exit 1
